// ==== logic/decodePkg.sv ====
// Shared widths, opcode encodings and immediate kinds for the decode stage.
// Modules refer to these by scoped name.
package decodePkg;

    localparam int dataWidth    = 16; // Data word width.
    localparam int regAddrWidth = 3;  // Register index width.

    localparam logic [regAddrWidth-1:0] linkReg = 3'd7; // Return address register.

    typedef logic [4:0] opcodeT;

    // Control and special instructions.
    localparam opcodeT opHalt  = 5'b00000;
    localparam opcodeT opNop   = 5'b00001;

    // I1 format ALU immediates.
    localparam opcodeT opAddi  = 5'b01000;
    localparam opcodeT opSubi  = 5'b01001;
    localparam opcodeT opXori  = 5'b01010;
    localparam opcodeT opAndni = 5'b01011;

    // I1 format memory access.
    localparam opcodeT opSt    = 5'b10000;
    localparam opcodeT opLd    = 5'b10001;
    localparam opcodeT opStu   = 5'b10011;

    // I2 format immediate loads.
    localparam opcodeT opLbi   = 5'b11000;
    localparam opcodeT opSlbi  = 5'b10010;

    // Jumps, direct and register relative.
    localparam opcodeT opJ     = 5'b00100;
    localparam opcodeT opJr    = 5'b00101;
    localparam opcodeT opJal   = 5'b00110;
    localparam opcodeT opJalr  = 5'b00111;

    localparam opcodeT opBeqz  = 5'b01100; // I2 format branch.
    localparam opcodeT opArith = 5'b11011; // R format ADD/SUB/XOR/ANDN.

    // Source field of the immediate.
    typedef enum logic {
        immShort, // Bits 4..0, I1.
        immLong   // Bits 7..0, I2.
    } immKindT;

endpackage

// ==== logic/ctrlIf.sv ====
// Decoded control levels passed from the control unit to the decode datapath.
// The control unit owns every signal; the datapath only reads them.
interface ctrlIf;

    logic regWrite; // Register file write enable.
    logic regDst;   // Write to R format Rd.
    logic i1Fmt;    // Instruction is I1 format.
    logic zeroExt;  // Zero extend the immediate.
    logic memWrite; // Store, operands swapped.
    logic aluSrc;   // Register relative jump.
    logic jump;
    logic isLink;   // JAL or JALR.
    logic isStu;    // Store with update.

    modport ctrl (
        output regWrite, regDst, i1Fmt, zeroExt, memWrite,
        output aluSrc, jump, isLink, isStu
    );

    modport stage (
        input regWrite, regDst, i1Fmt, zeroExt, memWrite,
        input aluSrc, jump, isLink, isStu
    );

endinterface

// ==== logic/controlUnit.sv ====
// Opcode decoder for the decode stage.
// Drives the control bundle and flags opcodes outside the supported set.
module controlUnit (
    input  logic [decodePkg::dataWidth-1:0] instr,
    ctrlIf.ctrl                             ctrl,
    output logic                            err
);

    decodePkg::opcodeT opcode;

    assign opcode = instr[15:11];

    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.regDst   = 1'b0;
        ctrl.i1Fmt    = 1'b0;
        ctrl.zeroExt  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.isLink   = 1'b0;
        ctrl.isStu    = 1'b0;
        err           = 1'b0;
        case (opcode)
            decodePkg::opHalt, decodePkg::opNop, decodePkg::opBeqz: begin
                // Defaults hold.
            end
            decodePkg::opAddi, decodePkg::opSubi, decodePkg::opLd: begin
                ctrl.regWrite = 1'b1;
                ctrl.i1Fmt    = 1'b1;
            end
            decodePkg::opXori, decodePkg::opAndni: begin
                ctrl.regWrite = 1'b1;
                ctrl.i1Fmt    = 1'b1;
                ctrl.zeroExt  = 1'b1; // Logical ops take unsigned immediates.
            end
            decodePkg::opSt: begin
                ctrl.i1Fmt    = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            decodePkg::opStu: begin
                ctrl.regWrite = 1'b1; // Updated base goes back to Rs.
                ctrl.i1Fmt    = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.isStu    = 1'b1;
            end
            decodePkg::opLbi: begin
                ctrl.regWrite = 1'b1;
            end
            decodePkg::opSlbi: begin
                ctrl.regWrite = 1'b1;
                ctrl.zeroExt  = 1'b1;
            end
            decodePkg::opJ: begin
                ctrl.jump = 1'b1;
            end
            decodePkg::opJr: begin
                ctrl.jump   = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            decodePkg::opJal, decodePkg::opJalr: begin
                ctrl.jump     = 1'b1;
                ctrl.aluSrc   = (opcode == decodePkg::opJalr); // JALR is register relative.
                ctrl.regWrite = 1'b1;
                ctrl.isLink   = 1'b1;
            end
            decodePkg::opArith: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
            end
            default: begin
                err = 1'b1; // All controls stay low.
            end
        endcase
    end

endmodule

// ==== logic/regFile.sv ====
// General register file with two combinational read ports and one write port.
// Writes land at the rising clock edge, with no bypass to the read ports.
module regFile #(
    parameter int numRegs = 8
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [decodePkg::regAddrWidth-1:0] read1Sel,
    input  logic [decodePkg::regAddrWidth-1:0] read2Sel,
    input  logic [decodePkg::regAddrWidth-1:0] writeSel,
    input  logic [decodePkg::dataWidth-1:0]    writeData,
    input  logic                               writeEn,
    output logic [decodePkg::dataWidth-1:0]    read1Data,
    output logic [decodePkg::dataWidth-1:0]    read2Data
);

    logic [decodePkg::dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0; // All registers read zero after reset.
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    assign read1Data = regs[read1Sel]; // Old value until the edge.
    assign read2Data = regs[read2Sel];

    // An X on the write path would corrupt a register silently.
    assert property (@(posedge clk) disable iff (!rstN)
        writeEn |-> !$isunknown({writeSel, writeData}))
        else $error("unknown write index or data while writeEn is high");

endmodule

// ==== logic/immGen.sv ====
// Immediate and jump displacement builder.
// Picks the I1 or I2 immediate field and extends both it and the displacement.
module immGen (
    input  logic [decodePkg::dataWidth-1:0] instr,
    input  logic                            i1Fmt,
    input  logic                            zeroExt,
    input  logic                            jumpReg,
    output logic [decodePkg::dataWidth-1:0] immVal,
    output logic [decodePkg::dataWidth-1:0] jumpAddr
);

    localparam int dw = decodePkg::dataWidth;

    decodePkg::immKindT immKind;

    assign immKind = i1Fmt ? decodePkg::immShort : decodePkg::immLong;

    always_comb begin
        case (immKind)
            decodePkg::immShort: begin
                immVal = zeroExt ? {{(dw-5){1'b0}}, instr[4:0]}
                                 : {{(dw-5){instr[4]}}, instr[4:0]};
            end
            default: begin
                immVal = zeroExt ? {{(dw-8){1'b0}}, instr[7:0]}
                                 : {{(dw-8){instr[7]}}, instr[7:0]};
            end
        endcase
    end

    // JR and JALR carry an 8-bit offset; J and JAL an 11-bit one.
    assign jumpAddr = jumpReg ? {{(dw-8){instr[7]}}, instr[7:0]}
                              : {{(dw-11){instr[10]}}, instr[10:0]};

endmodule

// ==== logic/decodeStage.sv ====
// Decode datapath: register reads, writeback selection and immediate building.
// Driven by the control bundle from the opcode decoder.
module decodeStage #(
    parameter int numRegs = 8
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [decodePkg::dataWidth-1:0] instr,
    input  logic [decodePkg::dataWidth-1:0] pc,
    input  logic [decodePkg::dataWidth-1:0] writeData,
    ctrlIf.stage                            ctrl,
    output logic [decodePkg::dataWidth-1:0] readData1,
    output logic [decodePkg::dataWidth-1:0] readData2,
    output logic [decodePkg::dataWidth-1:0] immVal,
    output logic [decodePkg::dataWidth-1:0] jumpAddr
);

    logic [decodePkg::regAddrWidth-1:0] rsIdx;
    logic [decodePkg::regAddrWidth-1:0] rtIdx;
    logic [decodePkg::regAddrWidth-1:0] rdIdx;
    logic [decodePkg::regAddrWidth-1:0] writeSel;
    logic [decodePkg::dataWidth-1:0]    writeDataSel;
    logic [decodePkg::dataWidth-1:0]    port1Data;
    logic [decodePkg::dataWidth-1:0]    port2Data;

    assign rsIdx = instr[10:8];
    assign rtIdx = instr[7:5];
    assign rdIdx = instr[4:2]; // R format only.

    always_comb begin
        if (ctrl.isLink) begin
            writeSel = decodePkg::linkReg;
        end else if (ctrl.isStu) begin
            writeSel = rsIdx; // Updated base address.
        end else if (ctrl.i1Fmt) begin
            writeSel = rtIdx;
        end else if (ctrl.regDst) begin
            writeSel = rdIdx;
        end else begin
            writeSel = rsIdx; // LBI and SLBI write Rs.
        end
    end

    assign writeDataSel = ctrl.isLink ? pc : writeData; // Links save the return address.

    regFile #(
        .numRegs(numRegs)
    ) regs (
        .clk      (clk),
        .rstN     (rstN),
        .read1Sel (rtIdx),
        .read2Sel (rsIdx),
        .writeSel (writeSel),
        .writeData(writeDataSel),
        .writeEn  (ctrl.regWrite),
        .read1Data(port1Data),
        .read2Data(port2Data)
    );

    // Stores present Rs as the address base on the first operand.
    assign readData1 = ctrl.memWrite ? port2Data : port1Data;
    assign readData2 = ctrl.memWrite ? port1Data : port2Data;

    immGen imm (
        .instr   (instr),
        .i1Fmt   (ctrl.i1Fmt),
        .zeroExt (ctrl.zeroExt),
        .jumpReg (ctrl.jump & ctrl.aluSrc),
        .immVal  (immVal),
        .jumpAddr(jumpAddr)
    );

    // Only STU both stores and writes back to the register file.
    assert property (@(posedge clk) disable iff (!rstN)
        (ctrl.memWrite && ctrl.regWrite) |-> ctrl.isStu)
        else $error("memWrite and regWrite both high outside STU");

endmodule

// ==== logic/decodeTop.sv ====
// Top level of the decode stage with plain ports.
// Joins the opcode decoder and the decode datapath through the control bundle.
module decodeTop #(
    parameter int numRegs = 8
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [decodePkg::dataWidth-1:0] instr,
    input  logic [decodePkg::dataWidth-1:0] pc,
    input  logic [decodePkg::dataWidth-1:0] writeData,
    output logic [decodePkg::dataWidth-1:0] readData1,
    output logic [decodePkg::dataWidth-1:0] readData2,
    output logic [decodePkg::dataWidth-1:0] immVal,
    output logic [decodePkg::dataWidth-1:0] jumpAddr,
    output logic                            regWrite,
    output logic                            memWrite,
    output logic                            aluSrc,
    output logic                            jump,
    output logic                            err
);

    ctrlIf ctrlBus ();

    controlUnit ctrlDec (
        .instr(instr),
        .ctrl (ctrlBus.ctrl),
        .err  (err)
    );

    decodeStage #(
        .numRegs(numRegs)
    ) stage (
        .clk      (clk),
        .rstN     (rstN),
        .instr    (instr),
        .pc       (pc),
        .writeData(writeData),
        .ctrl     (ctrlBus.stage),
        .readData1(readData1),
        .readData2(readData2),
        .immVal   (immVal),
        .jumpAddr (jumpAddr)
    );

    assign regWrite = ctrlBus.regWrite; // Controls exposed for the execute stage.
    assign memWrite = ctrlBus.memWrite;
    assign aluSrc   = ctrlBus.aluSrc;
    assign jump     = ctrlBus.jump;

endmodule

// ==== verification/decodeTb.sv ====
// Testbench for the decode stage top level.
// Replays the vectors in verification/decodeInput.txt, one per cycle, and checks all outputs.
module decodeTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int dw          = decodePkg::dataWidth;
    localparam int clkPeriod   = 20;
    localparam int driveSkew   = 1; // Offset from the clock edge for drive and sample.
    localparam int resetCycles = 5;

    typedef struct packed {
        logic [dw-1:0] instr;
        logic [dw-1:0] pc;
        logic [dw-1:0] writeData;
        logic [dw-1:0] readData1;
        logic [dw-1:0] readData2;
        logic [dw-1:0] immVal;
        logic [dw-1:0] jumpAddr;
        logic [4:0]    flags; // err, regWrite, memWrite, aluSrc, jump.
    } vectorT;

    logic          clk;
    logic          rstN;
    logic [dw-1:0] instr;
    logic [dw-1:0] pc;
    logic [dw-1:0] writeData;
    logic [dw-1:0] readData1;
    logic [dw-1:0] readData2;
    logic [dw-1:0] immVal;
    logic [dw-1:0] jumpAddr;
    logic          regWrite;
    logic          memWrite;
    logic          aluSrc;
    logic          jump;
    logic          err;

    vectorT vecQ[$];
    int     vecCount    = 0;
    bit     loaded      = 1'b0;
    int     wordErrors  = 0;
    int     bitErrors   = 0;
    int     otherErrors = 0;

    decodeTop #(
        .numRegs(8)
    ) uut (
        .clk      (clk),
        .rstN     (rstN),
        .instr    (instr),
        .pc       (pc),
        .writeData(writeData),
        .readData1(readData1),
        .readData2(readData2),
        .immVal   (immVal),
        .jumpAddr (jumpAddr),
        .regWrite (regWrite),
        .memWrite (memWrite),
        .aluSrc   (aluSrc),
        .jump     (jump),
        .err      (err)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic loadVectors();
        int            fd;
        int            fieldCount;
        string         line;
        logic [dw-1:0] fields [8];
        vectorT        vec;
        fd = $fopen("verification/decodeInput.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open verification/decodeInput.txt");
            otherErrors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 1) == "//") begin
                continue; // Blank or comment line.
            end
            fieldCount = $sscanf(line, "%h %h %h %h %h %h %h %h", fields[0], fields[1],
                                 fields[2], fields[3], fields[4], fields[5], fields[6],
                                 fields[7]);
            if (fieldCount != 8) begin
                $display("Error: malformed vector line: %s", line);
                otherErrors++;
            end else begin
                vec.instr     = fields[0];
                vec.pc        = fields[1];
                vec.writeData = fields[2];
                vec.readData1 = fields[3];
                vec.readData2 = fields[4];
                vec.immVal    = fields[5];
                vec.jumpAddr  = fields[6];
                vec.flags     = fields[7][4:0];
                vecQ.push_back(vec);
            end
        end
        $fclose(fd);
    endtask

    task automatic applyVector(input vectorT vec);
        instr     = vec.instr;
        pc        = vec.pc;
        writeData = vec.writeData;
    endtask

    task automatic checkWord(input string name, input logic [dw-1:0] expected,
                             input logic [dw-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            wordErrors++;
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
            bitErrors++;
        end
    endtask

    task automatic compareOutputs(input int idx, input vectorT vec);
        string tag;
        tag = $sformatf("vector %0d (instr %h)", idx, vec.instr);
        checkWord({tag, " readData1"}, vec.readData1, readData1);
        checkWord({tag, " readData2"}, vec.readData2, readData2);
        checkWord({tag, " immVal"}, vec.immVal, immVal);
        checkWord({tag, " jumpAddr"}, vec.jumpAddr, jumpAddr);
        checkBit({tag, " err"}, vec.flags[4], err);
        checkBit({tag, " regWrite"}, vec.flags[3], regWrite);
        checkBit({tag, " memWrite"}, vec.flags[2], memWrite);
        checkBit({tag, " aluSrc"}, vec.flags[1], aluSrc);
        checkBit({tag, " jump"}, vec.flags[0], jump);
    endtask

    initial begin : stimulus
        clk       = 1'b0;
        rstN      = 1'b0;
        instr     = '0;
        pc        = '0;
        writeData = '0;
        loadVectors();
        vecCount = vecQ.size();
        loaded   = 1'b1;
        if (vecCount == 0) begin
            $display("Error: no test vectors were loaded");
            otherErrors++;
        end
        repeat (resetCycles) @(posedge clk);
        #(driveSkew);
        rstN = 1'b1;
        for (int i = 0; i < vecCount; i++) begin
            applyVector(vecQ[i]);
            #(clkPeriod - 2 * driveSkew); // Sample just before the write edge.
            compareOutputs(i, vecQ[i]);
            @(posedge clk);
            #(driveSkew);
        end
        $display("Errors: %0d word mismatches, %0d flag mismatches, %0d other",
                 wordErrors, bitErrors, otherErrors);
        if (wordErrors + bitErrors + otherErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        #((vecCount + 10) * clkPeriod);
        otherErrors++;
        $display("Error: timeout, run did not finish within %0d cycles", vecCount + 10);
        $display("Errors: %0d word mismatches, %0d flag mismatches, %0d other",
                 wordErrors, bitErrors, otherErrors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== verification/decodeInput.txt ====
// instr pc writeData readData1 readData2 immVal jumpAddr flags, all hex, one cycle per line
// flags: bit4 err, bit3 regWrite, bit2 memWrite, bit1 aluSrc, bit0 jump
0000 0000 0000 0000 0000 0000 0000 00 // halt, r0 zero after reset
0f60 0002 0000 0000 0000 0060 ff60 00 // nop, r3 and r7 zero after reset
c185 0004 a5a5 0000 0000 ff85 0185 08 // lbi writes r1, same cycle reads old value
0920 0006 0000 a5a5 a5a5 0020 0120 00 // nop, r1 read back
d954 0008 1357 0000 a5a5 0054 0154 08 // arith writes rd r5
457f 000a 2468 0000 1357 ffff fd7f 08 // addi writes rt r3, r5 read back
53d3 000c 0f0f 0000 2468 0013 03d3 08 // xori zero extends, writes r6
5ed0 000e 00f0 0f0f 0f0f 0010 fed0 08 // andni zero extends, writes r6
48d0 0010 0042 00f0 0000 fff0 00d0 08 // subi sign extends, writes r6
929c 0012 beef 0000 0000 009c 029c 08 // slbi zero extends, writes rs r2
82a4 0014 dead beef 1357 0004 02a4 04 // st, operands swapped, no write
8a9e 0016 7777 0000 beef fffe 029e 08 // ld writes r4
9b82 0018 246a 2468 7777 0002 0382 0c // stu swapped, writes rs r3
2400 001a 0000 0000 7777 0000 fc00 01 // j, 11-bit negative displacement
2b80 001c 0000 7777 246a ff80 ff80 03 // jr, 8-bit displacement, r3 from stu
3123 001e 5555 a5a5 a5a5 0023 0123 09 // jal writes pc into r7
3f7f 0020 6666 246a 001e 007f 007f 0b // jalr reads r7 from jal, writes pc
0fe0 0022 0000 0020 0020 ffe0 ffe0 00 // nop, r7 holds jalr pc
fdc0 0024 9999 0042 1357 ffc0 fdc0 10 // unsupported opcode, no controls
6540 0026 0000 beef 1357 0040 fd40 00 // beqz, r5 left unchanged

// ==== sources.f ====
logic/decodePkg.sv
logic/ctrlIf.sv
logic/controlUnit.sv
logic/regFile.sv
logic/immGen.sv
logic/decodeStage.sv
logic/decodeTop.sv
verification/decodeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compiles the decode stage testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps --top-module decodeTb \
    -f sources.f -o decodeSim \
    && ./obj_dir/decodeSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation reported failures"; exit 1; }
exit 0
